// File: arcade_input.f
+incdir+test
hdl/arcade_timing_pkg.sv
hdl/arcade_ctrl_pkg.sv
hdl/clock_enable_gen.sv
hdl/key_event_filter.sv
hdl/key_event_fifo.sv
hdl/control_mapper.sv
hdl/arcade_input_top.sv
test/arcade_input_tb.sv

// File: hdl/arcade_ctrl_pkg.sv
//======================================
// Arcade player control types
//======================================

package arcade_ctrl_pkg;

	//======================================
	// Host scan codes
	//======================================

	// Only the keys the game reads
	typedef enum logic [7:0] {
		KEY_ONE_PLAYER  = 8'h05, // F1
		KEY_TWO_PLAYERS = 8'h06, // F2
		KEY_FIRE        = 8'h29, // Space
		KEY_LEFT        = 8'h6B,
		KEY_DOWN        = 8'h72,
		KEY_RIGHT       = 8'h74,
		KEY_UP          = 8'h75,
		KEY_COIN        = 8'h76  // ESC
	} key_code_e;

	// Logical key, also the index into the key state
	typedef enum logic [2:0] {
		ID_UP,
		ID_DOWN,
		ID_LEFT,
		ID_RIGHT,
		ID_COIN,
		ID_ONE_PLAYER,
		ID_TWO_PLAYERS,
		ID_FIRE
	} key_id_e;

	// One press or release
	typedef struct packed {
		key_id_e id;
		logic    pressed;
	} key_event_t;

	//======================================
	// Player controls
	//======================================

	// Host joystick, bit 0 is right
	typedef struct packed {
		logic fire2;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joystick_t;

	// Game button vector, active low
	typedef struct packed {
		logic two_players;
		logic fire;
		logic coin;
		logic one_player;
		logic right;
		logic left;
		logic down;
		logic up;
	} button_vec_t;

endpackage : arcade_ctrl_pkg

// File: hdl/arcade_input_top.sv
//======================================
// Arcade player input top
//======================================

`timescale 1ns/1ps

module arcade_input_top
	import arcade_ctrl_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        key_strobe,
	input  logic        key_pressed,
	input  logic [7:0]  key_code,
	input  logic        rotate,
	input  joystick_t   joystick_0,
	input  joystick_t   joystick_1,
	output button_vec_t button_in,
	output logic        key_overflow,
	output logic        ce_12,
	output logic        ce_6p,
	output logic        ce_6n,
	output logic        ce_1p79
);

	logic       push_valid;
	key_event_t push_event;
	logic       pop;
	logic       pop_valid;
	key_event_t pop_event;
	logic       credit_return;

	clock_enable_gen u_clock_enable_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_1p79 (ce_1p79)
	);

	// Producer, spends credits
	key_event_filter u_key_event_filter (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.key_strobe    (key_strobe),
		.key_pressed   (key_pressed),
		.key_code      (key_code),
		.credit_return (credit_return),
		.push_valid    (push_valid),
		.push_event    (push_event),
		.key_overflow  (key_overflow)
	);

	key_event_fifo u_key_event_fifo (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.push_valid    (push_valid),
		.push_event    (push_event),
		.pop           (pop),
		.pop_valid     (pop_valid),
		.pop_event     (pop_event),
		.credit_return (credit_return)
	);

	// Consumer, pops on the 6 enable
	control_mapper u_control_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ce_6p      (ce_6p),
		.pop_valid  (pop_valid),
		.pop_event  (pop_event),
		.pop        (pop),
		.rotate     (rotate),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.button_in  (button_in)
	);

endmodule : arcade_input_top

// File: hdl/arcade_timing_pkg.sv
//======================================
// Arcade input timing constants
//======================================

package arcade_timing_pkg;

	//======================================
	// Game clock enables
	//======================================

	// Free divider for the 12 and 6 enables
	localparam int CE_MAIN_DIV_W = 2;

	// Slow divider counts 13 down to 0, so one pulse in 14 clocks
	localparam logic [3:0] CE_SLOW_RELOAD = 4'd13;

	//======================================
	// Key event buffer
	//======================================

	// Buffer depth, also the credits the producer starts with
	localparam int KEY_FIFO_DEPTH = 4;

	// Credit counter holds 0 to KEY_FIFO_DEPTH
	localparam int CREDIT_W = $clog2(KEY_FIFO_DEPTH + 1);

endpackage : arcade_timing_pkg

// File: hdl/clock_enable_gen.sv
//======================================
// Game clock enables
//======================================

`timescale 1ns/1ps

module clock_enable_gen
	import arcade_timing_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79
);

	logic [CE_MAIN_DIV_W-1:0]       div_main;
	logic [$bits(CE_SLOW_RELOAD)-1:0] div_slow;

	// 12 and 6 enables from the free counter
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_main <= '0;
			ce_12    <= 1'b0;
			ce_6p    <= 1'b0;
			ce_6n    <= 1'b0;
		end else begin
			div_main <= div_main + 1'b1;
			ce_12    <= div_main[0];
			ce_6p    <= div_main[0] & ~div_main[1]; // Count 1
			ce_6n    <= div_main[0] &  div_main[1]; // Count 3
		end
	end

	// Slow enable, reloads at zero
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_slow <= CE_SLOW_RELOAD;
			ce_1p79  <= 1'b0;
		end else if (div_slow == '0) begin
			div_slow <= CE_SLOW_RELOAD;
			ce_1p79  <= 1'b1;
		end else begin
			div_slow <= div_slow - 1'b1;
			ce_1p79  <= 1'b0;
		end
	end

endmodule : clock_enable_gen

// File: hdl/control_mapper.sv
//======================================
// Key state and button mapping
//======================================

`timescale 1ns/1ps

module control_mapper
	import arcade_ctrl_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        ce_6p,
	input  logic        pop_valid,
	input  key_event_t  pop_event,
	output logic        pop,
	input  logic        rotate,
	input  joystick_t   joystick_0,
	input  joystick_t   joystick_1,
	output button_vec_t button_in
);

	logic [7:0]  key_state; // Indexed by key_id_e
	logic        src_up;
	logic        src_down;
	logic        src_left;
	logic        src_right;
	button_vec_t btn_act;

	// Take one event per game enable
	assign pop = ce_6p & pop_valid;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			key_state <= '0;
		else if (pop)
			key_state[pop_event.id] <= pop_event.pressed;
	end

	//======================================
	// Direction sources
	//======================================

	assign src_up    = key_state[ID_UP]    | joystick_0.up    | joystick_1.up;
	assign src_down  = key_state[ID_DOWN]  | joystick_0.down  | joystick_1.down;
	assign src_left  = key_state[ID_LEFT]  | joystick_0.left  | joystick_1.left;
	assign src_right = key_state[ID_RIGHT] | joystick_0.right | joystick_1.right;

	// Active high buttons before inversion
	always_comb begin
		btn_act.two_players = key_state[ID_TWO_PLAYERS];
		btn_act.one_player  = key_state[ID_ONE_PLAYER];
		btn_act.coin        = key_state[ID_COIN];
		btn_act.fire        = key_state[ID_FIRE] | joystick_0.fire | joystick_1.fire;

		if (rotate) begin
			btn_act.up    = src_up;
			btn_act.down  = src_down;
			btn_act.left  = src_left;
			btn_act.right = src_right;
		end else begin
			// Quarter turn for the rotated cabinet
			btn_act.up    = src_left;
			btn_act.down  = src_right;
			btn_act.left  = src_down;
			btn_act.right = src_up;
		end
	end

	// Game expects active low
	assign button_in = ~btn_act;

endmodule : control_mapper

// File: hdl/key_event_fifo.sv
//======================================
// Key event buffer
//======================================

`timescale 1ns/1ps

module key_event_fifo
	import arcade_timing_pkg::*;
	import arcade_ctrl_pkg::*;
#(
	parameter int DEPTH = KEY_FIFO_DEPTH
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       push_valid,
	input  key_event_t push_event,
	input  logic       pop,
	output logic       pop_valid,
	output key_event_t pop_event,
	output logic       credit_return
);

	localparam int PTR_W = $clog2(DEPTH);

	key_event_t       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_pop;

	// Credits keep the producer from pushing into a full buffer
	assign do_pop = pop & pop_valid;

	// Storage
	always_ff @(posedge clk_sys) begin
		if (push_valid)
			mem[wr_ptr] <= push_event;
	end

	// Pointers wrap on their own for a power of two depth
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_valid, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//======================================
	// Head of buffer
	//======================================

	assign pop_valid = (count != '0);
	assign pop_event = mem[rd_ptr];

	// One credit back per pop taken
	assign credit_return = do_pop;

endmodule : key_event_fifo

// File: hdl/key_event_filter.sv
//======================================
// Key event producer
//======================================

`timescale 1ns/1ps

module key_event_filter
	import arcade_timing_pkg::*;
	import arcade_ctrl_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic [7:0] key_code,
	input  logic       credit_return,
	output logic       push_valid,
	output key_event_t push_event,
	output logic       key_overflow
);

	logic                code_ok;
	key_id_e             code_id;
	logic                accepted;
	logic                spend;
	logic [CREDIT_W-1:0] credits;

	// Scan code to logical key
	always_comb begin
		code_ok = 1'b1;
		code_id = ID_UP;
		case (key_code)
			KEY_UP:          code_id = ID_UP;
			KEY_DOWN:        code_id = ID_DOWN;
			KEY_LEFT:        code_id = ID_LEFT;
			KEY_RIGHT:       code_id = ID_RIGHT;
			KEY_COIN:        code_id = ID_COIN;
			KEY_ONE_PLAYER:  code_id = ID_ONE_PLAYER;
			KEY_TWO_PLAYERS: code_id = ID_TWO_PLAYERS;
			KEY_FIRE:        code_id = ID_FIRE;
			default:         code_ok = 1'b0; // Not a game key
		endcase
	end

	assign accepted = key_strobe & code_ok;
	assign spend    = accepted & (credits != '0);

	// Credits and overflow
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			credits      <= CREDIT_W'(KEY_FIFO_DEPTH);
			push_valid   <= 1'b0;
			key_overflow <= 1'b0;
		end else begin
			push_valid <= spend;
			case ({spend, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // Both or neither
			endcase
			if (accepted && credits == '0)
				key_overflow <= 1'b1; // Sticky until reset
		end
	end

	// Event payload
	always_ff @(posedge clk_sys) begin
		if (spend) begin
			push_event.id      <= code_id;
			push_event.pressed <= key_pressed;
		end
	end

endmodule : key_event_filter

// File: test/arcade_input_checks.svh
//======================================
// Testbench compare tasks
//======================================

`ifndef ARCADE_INPUT_CHECKS_SVH
`define ARCADE_INPUT_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;

task automatic check_buttons(input string name, input button_vec_t exp, input button_vec_t act);
	if (act === exp) begin
		pass_count++;
		$display("ok    %s", name);
	end else begin
		fail_count++;
		$display("error %s: expected %b, actual %b", name, exp, act);
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act == exp) begin
		pass_count++;
		$display("ok    %s", name);
	end else begin
		fail_count++;
		$display("error %s: expected %0d, actual %0d", name, exp, act);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act === exp) begin
		pass_count++;
		$display("ok    %s", name);
	end else begin
		fail_count++;
		$display("error %s: expected %b, actual %b", name, exp, act);
	end
endtask

`endif

// File: test/arcade_input_tb.sv
//======================================
// Arcade input testbench
//======================================

`timescale 1ns/1ps

module arcade_input_tb
	import arcade_ctrl_pkg::*;
;

	localparam int          N_ROWS        = 23;
	localparam int          WAIT_CYCLES   = 40; // Poll limit per wait
	localparam int          SETTLE_CYCLES = 16;
	localparam int          WATCHDOG_NS   = 1_000_000;
	localparam button_vec_t NO_BUTTONS    = '1;

	`include "arcade_input_checks.svh"

	typedef struct packed {
		logic       strobe;
		logic [7:0] code;
		logic       pressed;
		joystick_t  j0;
		joystick_t  j1;
		logic       rot;
	} stim_row_t;

	logic        clk_sys;
	logic        rst_n;
	logic        key_strobe;
	logic        key_pressed;
	logic [7:0]  key_code;
	logic        rotate;
	joystick_t   joystick_0;
	joystick_t   joystick_1;
	button_vec_t button_in;
	logic        key_overflow;
	logic        ce_12;
	logic        ce_6p;
	logic        ce_6n;
	logic        ce_1p79;

	stim_row_t   stim_table [N_ROWS];
	logic [7:0]  model_keys; // Pressed bit per logical key
	int          seed = 32'h36f9_8635;

	arcade_input_top DUT (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_code     (key_code),
		.rotate       (rotate),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.button_in    (button_in),
		.key_overflow (key_overflow),
		.ce_12        (ce_12),
		.ce_6p        (ce_6p),
		.ce_6n        (ce_6n),
		.ce_1p79      (ce_1p79)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	//======================================
	// Reference model
	//======================================

	// Game key index for a scan code, -1 when the game ignores it
	function automatic int code_index(input logic [7:0] code);
		case (code)
			8'h75:   return ID_UP;
			8'h72:   return ID_DOWN;
			8'h6B:   return ID_LEFT;
			8'h74:   return ID_RIGHT;
			8'h76:   return ID_COIN;
			8'h05:   return ID_ONE_PLAYER;
			8'h06:   return ID_TWO_PLAYERS;
			8'h29:   return ID_FIRE;
			default: return -1;
		endcase
	endfunction

	function automatic button_vec_t expected_buttons(input logic [7:0] keys,
			input joystick_t j0, input joystick_t j1, input logic rot);
		button_vec_t b;
		logic        u, d, l, r;
		u = keys[ID_UP]    | j0.up    | j1.up;
		d = keys[ID_DOWN]  | j0.down  | j1.down;
		l = keys[ID_LEFT]  | j0.left  | j1.left;
		r = keys[ID_RIGHT] | j0.right | j1.right;
		b.two_players = ~keys[ID_TWO_PLAYERS];
		b.one_player  = ~keys[ID_ONE_PLAYER];
		b.coin        = ~keys[ID_COIN];
		b.fire        = ~(keys[ID_FIRE] | j0.fire | j1.fire);
		b.up          = rot ? ~u : ~l; // Unrotated cabinet turns a quarter
		b.down        = rot ? ~d : ~r;
		b.left        = rot ? ~l : ~d;
		b.right       = rot ? ~r : ~u;
		return b;
	endfunction

	task automatic build_table();
		logic [31:0] rnd_a;
		logic [31:0] rnd_b;
		rnd_a = $random(seed);
		rnd_b = $random(seed);
		stim_table[0]  = '{1'b1, 8'h75, 1'b1, '0, '0, 1'b1};
		stim_table[1]  = '{1'b1, 8'h75, 1'b0, '0, '0, 1'b1};
		stim_table[2]  = '{1'b1, 8'h72, 1'b1, '0, '0, 1'b1};
		stim_table[3]  = '{1'b1, 8'h72, 1'b0, '0, '0, 1'b1};
		stim_table[4]  = '{1'b1, 8'h6B, 1'b1, '0, '0, 1'b1};
		stim_table[5]  = '{1'b1, 8'h6B, 1'b0, '0, '0, 1'b1};
		stim_table[6]  = '{1'b1, 8'h74, 1'b1, '0, '0, 1'b1};
		stim_table[7]  = '{1'b1, 8'h74, 1'b0, '0, '0, 1'b1};
		stim_table[8]  = '{1'b1, 8'h76, 1'b1, '0, '0, 1'b1};
		stim_table[9]  = '{1'b1, 8'h05, 1'b1, '0, '0, 1'b1};
		stim_table[10] = '{1'b1, 8'h06, 1'b1, '0, '0, 1'b1};
		stim_table[11] = '{1'b1, 8'h29, 1'b1, '0, '0, 1'b1};
		stim_table[12] = '{1'b1, 8'h1C, 1'b1, '0, '0, 1'b1}; // Not a game key
		stim_table[13] = '{1'b1, 8'h76, 1'b0, '0, '0, 1'b1};
		stim_table[14] = '{1'b1, 8'h05, 1'b0, '0, '0, 1'b1};
		stim_table[15] = '{1'b1, 8'h06, 1'b0, '0, '0, 1'b1};
		stim_table[16] = '{1'b1, 8'h29, 1'b0, '0, '0, 1'b1};
		stim_table[17] = '{1'b1, 8'h75, 1'b1, '0, '0, 1'b0};
		stim_table[18] = '{1'b1, 8'h75, 1'b0, '0, '0, 1'b0};
		stim_table[19] = '{1'b0, 8'h00, 1'b0, rnd_a[5:0], '0, 1'b1};
		stim_table[20] = '{1'b0, 8'h00, 1'b0, '0, rnd_b[5:0], 1'b0};
		stim_table[21] = '{1'b0, 8'h00, 1'b0, 6'b01_0000, '0, 1'b1}; // Fire only
		stim_table[22] = '{1'b0, 8'h00, 1'b0, '0, '0, 1'b0};
	endtask

	//======================================
	// Helpers
	//======================================

	task automatic apply_reset();
		@(negedge clk_sys);
		rst_n      = 1'b0;
		key_strobe = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		model_keys = '0;
		repeat (5) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic wait_for_buttons(input string name, input button_vec_t exp);
		int cycles;
		cycles = 0;
		while (button_in !== exp && cycles < WAIT_CYCLES) begin
			@(negedge clk_sys);
			cycles++;
		end
		check_buttons(name, exp, button_in); // Last value seen on a timeout
	endtask

	task automatic wait_for_flag(input string name, input logic exp);
		int cycles;
		cycles = 0;
		while (key_overflow !== exp && cycles < WAIT_CYCLES) begin
			@(negedge clk_sys);
			cycles++;
		end
		check_flag(name, exp, key_overflow);
	endtask

	task automatic count_enables();
		int n12;
		int n6p;
		int n6n;
		int n179;
		int overlap;
		n12     = 0;
		n6p     = 0;
		n6n     = 0;
		n179    = 0;
		overlap = 0;
		repeat (280) begin
			@(negedge clk_sys);
			n12  += ce_12;
			n6p  += ce_6p;
			n6n  += ce_6n;
			n179 += ce_1p79;
			if (ce_6p && ce_6n)
				overlap++;
		end
		check_count("ce_12 pulses", 140, n12);
		check_count("ce_6p pulses", 70, n6p);
		check_count("ce_6n pulses", 70, n6n);
		check_count("ce_1p79 pulses", 20, n179);
		check_count("ce_6p and ce_6n overlap", 0, overlap);
	endtask

	// Watchdog for the whole run
	initial begin
		#(WATCHDOG_NS);
		$display("simulation ran past its time limit");
		$display("sim failed");
		$finish;
	end

	//======================================
	// Main sequence
	//======================================

	initial begin
		stim_row_t   row;
		int          idx;
		button_vec_t exp;
		logic        prev;
		int          edges;
		rst_n       = 1'b0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = 8'h00;
		rotate      = 1'b1;
		joystick_0  = '0;
		joystick_1  = '0;
		model_keys  = '0;
		build_table();
		apply_reset();
		check_buttons("reset buttons", NO_BUTTONS, button_in);
		check_flag("reset overflow", 1'b0, key_overflow);

		for (int i = 0; i < N_ROWS; i++) begin
			row = stim_table[i];
			@(negedge clk_sys);
			joystick_0  = row.j0;
			joystick_1  = row.j1;
			rotate      = row.rot;
			key_code    = row.code;
			key_pressed = row.pressed;
			key_strobe  = row.strobe;
			@(negedge clk_sys);
			key_strobe = 1'b0;
			idx = code_index(row.code);
			if (row.strobe && idx >= 0)
				model_keys[idx] = row.pressed;
			exp = expected_buttons(model_keys, row.j0, row.j1, row.rot);
			if (row.strobe && idx < 0) begin
				repeat (SETTLE_CYCLES) @(negedge clk_sys); // Nothing may change
				check_buttons($sformatf("table row %0d", i), exp, button_in);
			end else begin
				wait_for_buttons($sformatf("table row %0d", i), exp);
			end
		end

		count_enables();

		// Ten back to back strobes outrun the credits
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_sys);
			key_code    = 8'h29;
			key_pressed = 1'b1;
			key_strobe  = 1'b1;
		end
		@(negedge clk_sys);
		key_strobe = 1'b0;
		wait_for_flag("overflow raised", 1'b1);
		repeat (WAIT_CYCLES) @(negedge clk_sys);
		check_flag("overflow sticky", 1'b1, key_overflow);

		// Burst within capacity, every edge must show up in order
		apply_reset();
		check_buttons("reset buttons again", NO_BUTTONS, button_in);
		prev  = button_in.coin;
		edges = 0;
		for (int c = 0; c < WAIT_CYCLES && edges < 4; c++) begin
			@(negedge clk_sys);
			if (button_in.coin !== prev) begin
				edges++;
				prev = button_in.coin;
			end
			key_code    = 8'h76;
			key_pressed = (c % 2 == 0);
			key_strobe  = (c < 4);
		end
		key_strobe = 1'b0;
		check_count("burst coin edges", 4, edges);
		check_buttons("burst leaves coin released", NO_BUTTONS, button_in);
		check_flag("burst overflow", 1'b0, key_overflow);

		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule : arcade_input_tb
